//--- build.f
+incdir+include
hw/bridge_pkg.sv
hw/bridge_fifo.sv
hw/burst_addr_gen.sv
hw/apb_sequencer.sv
hw/axi2apb_top.sv
verif/axi2apb_checker.sv
verif/tb_axi2apb.sv

//--- hw/apb_sequencer.sv
// APB transfer sequencer
`default_nettype none
`include "bridge_config.svh"

module apb_sequencer
    import bridge_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         ar_valid,
    output logic        ar_ready,
    input  axi_cmd_t    ar_cmd,
    input  wire         aw_valid,
    output logic        aw_ready,
    input  axi_cmd_t    aw_cmd,
    input  wire         w_valid,
    output logic        w_ready,
    input  w_beat_t     w_beat,
    output logic        r_valid,
    input  wire         r_ready,
    output r_beat_t     r_beat,
    output logic        b_valid,
    input  wire         b_ready,
    output b_resp_t     b_resp,
    output logic        load,
    output logic        step,
    output axi_cmd_t    sel_cmd,
    input  wire  [31:0] beat_addr,
    input  wire         last_beat,
    input  wire         active,
    output logic        psel,
    output logic        penable,
    output logic        pwrite,
    output logic [31:0] paddr,
    output logic [31:0] pwdata,
    output logic [3:0]  pstrb,
    input  wire         pready,
    input  wire  [1:0]  presp,
    input  wire  [31:0] prdata
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOW_SETUP,
        ST_LOW_ACCESS,
        ST_HIGH_SETUP,
        ST_HIGH_ACCESS
    } state_e;

    state_e                  state_q;
    state_e                  state_d;
    logic                    is_write_q;
    logic                    err_q;
    logic [`BRIDGE_ID_W-1:0] id_q;
    logic [31:0]             low_data_q;
    logic [1:0]              low_resp_q;
    logic                    pick_read;
    logic                    pick_write;
    logic                    can_start;
    logic                    low_done;
    logic                    beat_done;
    logic                    high_phase;
    logic [1:0]              worse_resp;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Burst selection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign pick_read  = (state_q == ST_IDLE) && !active && ar_valid; // Reads win a tie
    assign pick_write = (state_q == ST_IDLE) && !active && !ar_valid
                        && aw_valid && w_valid && b_ready;
    assign load       = pick_read || pick_write;
    assign ar_ready   = pick_read;
    assign aw_ready   = pick_write;
    assign sel_cmd    = pick_read ? ar_cmd : aw_cmd;

    // A beat may open only once its data has room to land or is waiting
    assign can_start  = is_write_q ? w_valid : r_ready;
    assign low_done   = (state_q == ST_LOW_ACCESS) && pready;
    assign beat_done  = (state_q == ST_HIGH_ACCESS) && pready;
    assign step       = beat_done;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:        if (load) state_d = ST_LOW_SETUP;
            ST_LOW_SETUP:   if (can_start) state_d = ST_LOW_ACCESS;
            ST_LOW_ACCESS:  if (pready) state_d = ST_HIGH_SETUP;
            ST_HIGH_SETUP:  state_d = ST_HIGH_ACCESS;
            ST_HIGH_ACCESS: if (pready) state_d = last_beat ? ST_IDLE : ST_LOW_SETUP;
            default:        state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= ST_IDLE;
            is_write_q <= 1'b0;
            err_q      <= 1'b0;
        end else begin
            state_q <= state_d;
            if (load) begin
                is_write_q <= pick_write;
                err_q      <= 1'b0;
            end else if ((low_done || beat_done) && presp[1]) begin
                err_q <= 1'b1; // Sticky until the next burst
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            id_q <= sel_cmd.id;
        end
        if (low_done) begin
            low_data_q <= prdata;
            low_resp_q <= presp;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB drive
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign high_phase = (state_q == ST_HIGH_SETUP) || (state_q == ST_HIGH_ACCESS);
    assign psel       = ((state_q == ST_LOW_SETUP) && can_start) || (state_q == ST_LOW_ACCESS)
                        || high_phase;
    assign penable    = (state_q == ST_LOW_ACCESS) || (state_q == ST_HIGH_ACCESS);
    assign pwrite     = psel && is_write_q;
    assign paddr      = high_phase ? beat_addr + 32'd4 : beat_addr; // High word sits 4 bytes up
    assign pwdata     = high_phase ? w_beat.data[63:32] : w_beat.data[31:0];
    assign pstrb      = !is_write_q ? 4'b0000 :
                        high_phase  ? w_beat.strb[7:4] : w_beat.strb[3:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Responses
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign worse_resp = (presp > low_resp_q) ? presp : low_resp_q;

    assign r_valid = beat_done && !is_write_q;
    assign r_beat  = '{id: id_q, data: {prdata, low_data_q}, resp: worse_resp, last: last_beat};
    assign w_ready = beat_done && is_write_q;
    assign b_valid = beat_done && is_write_q && last_beat; // Room was checked at selection
    assign b_resp  = '{id: id_q, resp: (err_q || presp[1]) ? RESP_SLVERR : RESP_OKAY};

endmodule

`default_nettype wire

//--- hw/axi2apb_top.sv
// AXI to APB bridge top
`default_nettype none
`include "bridge_config.svh"

module axi2apb_top
    import bridge_pkg::*;
(
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire  [`BRIDGE_ID_W-1:0] arid,
    input  wire  [31:0]             araddr,
    input  wire  [7:0]              arlen,
    input  wire  [2:0]              arsize,
    input  wire  [1:0]              arburst,
    input  wire                     arvalid,
    output logic                    arready,
    output logic [`BRIDGE_ID_W-1:0] rid,
    output logic [63:0]             rdata,
    output logic [1:0]              rresp,
    output logic                    rlast,
    output logic                    rvalid,
    input  wire                     rready,
    input  wire  [`BRIDGE_ID_W-1:0] awid,
    input  wire  [31:0]             awaddr,
    input  wire  [7:0]              awlen,
    input  wire  [2:0]              awsize,
    input  wire  [1:0]              awburst,
    input  wire                     awvalid,
    output logic                    awready,
    input  wire  [63:0]             wdata,
    input  wire  [7:0]              wstrb,
    input  wire                     wlast,
    input  wire                     wvalid,
    output logic                    wready,
    output logic [`BRIDGE_ID_W-1:0] bid,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  wire                     bready,
    output logic                    psel,
    output logic [31:0]             paddr,
    output logic                    penable,
    output logic                    pwrite,
    output logic [31:0]             pwdata,
    input  wire                     pready,
    input  wire  [1:0]              presp,
    input  wire  [31:0]             prdata,
    output logic [3:0]              pstrb
);

    axi_cmd_t    ar_in, ar_head, aw_in, aw_head, sel_cmd;
    w_beat_t     w_in, w_head;
    r_beat_t     r_push, r_out;
    b_resp_t     b_push, b_out;
    logic        ar_head_valid, ar_pop, aw_head_valid, aw_pop, w_head_valid, w_pop;
    logic        r_push_valid, r_push_ready, b_push_valid, b_push_ready;
    logic        load, step, last_beat, active;
    logic [31:0] beat_addr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI field packing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign ar_in = '{id: arid, addr: araddr, len: arlen, size: arsize, burst: burst_e'(arburst)};
    assign aw_in = '{id: awid, addr: awaddr, len: awlen, size: awsize, burst: burst_e'(awburst)};
    assign w_in  = '{data: wdata, strb: wstrb, last: wlast};
    assign {rid, rdata, rresp, rlast} = r_out;
    assign {bid, bresp}               = b_out;

    bridge_fifo #(.entry_t(axi_cmd_t), .DEPTH(`BRIDGE_CMD_DEPTH)) ar_fifo (
        .clk(clk), .rst_n(rst_n),
        .in_valid(arvalid), .in_ready(arready), .in_data(ar_in),
        .out_valid(ar_head_valid), .out_ready(ar_pop), .out_data(ar_head)
    );

    bridge_fifo #(.entry_t(axi_cmd_t), .DEPTH(`BRIDGE_CMD_DEPTH)) aw_fifo (
        .clk(clk), .rst_n(rst_n),
        .in_valid(awvalid), .in_ready(awready), .in_data(aw_in),
        .out_valid(aw_head_valid), .out_ready(aw_pop), .out_data(aw_head)
    );

    bridge_fifo #(.entry_t(w_beat_t), .DEPTH(`BRIDGE_DATA_DEPTH)) w_fifo (
        .clk(clk), .rst_n(rst_n),
        .in_valid(wvalid), .in_ready(wready), .in_data(w_in),
        .out_valid(w_head_valid), .out_ready(w_pop), .out_data(w_head)
    );

    bridge_fifo #(.entry_t(r_beat_t), .DEPTH(`BRIDGE_DATA_DEPTH)) r_fifo (
        .clk(clk), .rst_n(rst_n),
        .in_valid(r_push_valid), .in_ready(r_push_ready), .in_data(r_push),
        .out_valid(rvalid), .out_ready(rready), .out_data(r_out)
    );

    bridge_fifo #(.entry_t(b_resp_t), .DEPTH(`BRIDGE_RESP_DEPTH)) b_fifo (
        .clk(clk), .rst_n(rst_n),
        .in_valid(b_push_valid), .in_ready(b_push_ready), .in_data(b_push),
        .out_valid(bvalid), .out_ready(bready), .out_data(b_out)
    );

    burst_addr_gen u_addr_gen (
        .clk(clk), .rst_n(rst_n),
        .load(load), .cmd(sel_cmd), .step(step),
        .beat_addr(beat_addr), .last_beat(last_beat), .active(active)
    );

    apb_sequencer u_seq (
        .clk(clk), .rst_n(rst_n),
        .ar_valid(ar_head_valid), .ar_ready(ar_pop), .ar_cmd(ar_head),
        .aw_valid(aw_head_valid), .aw_ready(aw_pop), .aw_cmd(aw_head),
        .w_valid(w_head_valid), .w_ready(w_pop), .w_beat(w_head),
        .r_valid(r_push_valid), .r_ready(r_push_ready), .r_beat(r_push),
        .b_valid(b_push_valid), .b_ready(b_push_ready), .b_resp(b_push),
        .load(load), .step(step), .sel_cmd(sel_cmd),
        .beat_addr(beat_addr), .last_beat(last_beat), .active(active),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
        .pready(pready), .presp(presp), .prdata(prdata)
    );

endmodule

`default_nettype wire

//--- hw/bridge_fifo.sv
// Synchronous valid/ready FIFO
`default_nettype none

module bridge_fifo #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = 4
) (
    input  wire    clk,
    input  wire    rst_n,
    input  wire    in_valid,
    output logic   in_ready,
    input  entry_t in_data,
    output logic   out_valid,
    input  wire    out_ready,
    output entry_t out_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    entry_t             mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               push;
    logic               pop;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither leave the fill level alone
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/bridge_pkg.sv
// AXI to APB bridge types
`default_nettype none
`include "bridge_config.svh"

package bridge_pkg;

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } burst_e;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // One AR or AW request
    typedef struct packed {
        logic [`BRIDGE_ID_W-1:0] id;
        logic [31:0]             addr;
        logic [7:0]              len;
        logic [2:0]              size;
        burst_e                  burst;
    } axi_cmd_t;

    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  strb;
        logic        last;
    } w_beat_t;

    typedef struct packed {
        logic [`BRIDGE_ID_W-1:0] id;
        logic [63:0]             data;
        logic [1:0]              resp;
        logic                    last;
    } r_beat_t;

    typedef struct packed {
        logic [`BRIDGE_ID_W-1:0] id;
        logic [1:0]              resp;
    } b_resp_t;

endpackage

`default_nettype wire

//--- hw/burst_addr_gen.sv
// Burst beat address generator
`default_nettype none

module burst_addr_gen
    import bridge_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         load,
    input  axi_cmd_t    cmd,
    input  wire         step,
    output logic [31:0] beat_addr,
    output logic        last_beat,
    output logic        active
);

    logic [31:0] addr_q;
    logic [31:0] wrap_mask_q;
    logic [2:0]  size_q;
    burst_e      burst_q;
    logic [8:0]  left_q;
    logic [31:0] beat_bytes;
    logic [31:0] next_addr;

    assign beat_bytes = 32'd1 << size_q;
    assign beat_addr  = addr_q;
    assign last_beat  = (left_q == 9'd1);

    always_comb begin
        case (burst_q)
            FIXED:   next_addr = addr_q;
            WRAP:    next_addr = (addr_q & ~wrap_mask_q) | ((addr_q + beat_bytes) & wrap_mask_q);
            default: next_addr = addr_q + beat_bytes; // Reserved encoding runs as INCR
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Burst context
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (load) begin
            addr_q      <= {cmd.addr[31:3], 3'b000};
            wrap_mask_q <= ((32'(cmd.len) + 32'd1) << cmd.size) - 32'd1; // Window of size times count
            size_q      <= cmd.size;
            burst_q     <= cmd.burst;
        end else if (step) begin
            addr_q <= next_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            left_q <= '0;
            active <= 1'b0;
        end else if (load) begin
            left_q <= {1'b0, cmd.len} + 9'd1;
            active <= 1'b1;
        end else if (step && active) begin
            left_q <= left_q - 9'd1;
            if (last_beat) begin
                active <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- include/bridge_config.svh
// Bridge build constants

`ifndef BRIDGE_CONFIG_SVH
`define BRIDGE_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI side
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define BRIDGE_ID_W 4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Buffer depths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define BRIDGE_CMD_DEPTH 4
`define BRIDGE_DATA_DEPTH 4
`define BRIDGE_RESP_DEPTH 4

`endif

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_axi2apb -f build.f -o sim_axi2apb

status=0
./obj_dir/sim_axi2apb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "^PASS: all tests$" sim.log; then
    exit 0
fi
echo "Simulation did not pass (exit status $status)"
exit 1

//--- verif/axi2apb_checker.sv
// Bridge protocol assertions
`default_nettype none

module axi2apb_checker (
    input wire        clk,
    input wire        rst_n,
    input wire        psel,
    input wire        penable,
    input wire        pready,
    input wire [31:0] paddr,
    input wire        rvalid,
    input wire        rready
);

    // Access phase always follows a setup phase
    a_setup_first: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(penable) |-> $past(psel))
        else $error("penable rose without a setup phase");

    a_access_next: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(psel) |=> penable)
        else $error("Setup phase not followed by access phase");

    a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (penable && !pready) |=> $stable(paddr))
        else $error("paddr changed during a wait state");

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (rvalid && !rready) |=> rvalid)
        else $error("rvalid dropped before rready");

endmodule

bind axi2apb_top axi2apb_checker u_checker (
    .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pready(pready),
    .paddr(paddr), .rvalid(rvalid), .rready(rready)
);

`default_nettype wire

//--- verif/axi2apb_testdata.txt
# R/W: id addr len burst (0 FIXED, 1 INCR, 2 WRAP), each W followed by D lines: data strb
# E: APB error word address, S: random stalls off/on, G: issue everything queued so far
E 208
E 318
R 1 100 3 1
G
R 2 150 3 2
R 3 180 2 0
G
W 4 40 1 1
D 1122334455667788 0f
D 99aabbccddeeff00 f0
W 5 60 2 0
D 0123456789abcdef 81
D fedcba9876543210 3c
D 0000000000000000 00
G
R 6 40 1 1
R 7 60 0 1
W 8 200 1 1
D aaaaaaaaaaaaaaaa ff
D bbbbbbbbbbbbbbbb ff
G
R 9 200 1 1
S 1
W a 310 3 2
D 1111111111111111 ff
D 2222222222222222 ff
D 3333333333333333 c3
D 4444444444444444 ff
R b 100 7 1
R c 118 3 2
G
R d 300 3 1
W e 80 0 1
D 5555666677778888 ff
G

//--- verif/tb_axi2apb.sv
// AXI to APB bridge testbench
`default_nettype none
`include "bridge_config.svh"

module tb_axi2apb;

    logic                    clk;
    logic                    rst_n;
    logic [`BRIDGE_ID_W-1:0] arid, awid, rid, bid;
    logic [31:0]             araddr, awaddr, paddr, pwdata, prdata;
    logic [7:0]              arlen, awlen, wstrb;
    logic [2:0]              arsize, awsize;
    logic [1:0]              arburst, awburst, rresp, bresp, presp;
    logic                    arvalid, arready, rlast, rvalid, rready;
    logic                    awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic [63:0]             wdata, rdata;
    logic                    psel, penable, pwrite, pready;
    logic [3:0]              pstrb;

    logic [31:0] apb_mem [256];
    logic [31:0] ref_mem [256];
    logic [31:0] err_q [$];
    logic [45:0] ar_q [$];     // {id, addr, len, burst}
    logic [45:0] aw_q [$];
    logic [72:0] w_q [$];      // {data, strb, last}
    logic [70:0] exp_r [$];    // {id, data, resp, last}
    logic [5:0]  exp_b [$];    // {id, resp}
    string       lines [$];
    logic [31:0] lfsr;
    bit          stall_mode;
    int          wait_cnt;
    int          budget_cycles;
    int          errors;

    axi2apb_top u_dut (.*);

    always #10 clk = ~clk;

    task automatic fail_now();
        $display("FAIL: see errors above");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
            fail_now();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [3:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr); // One step per bit taken
            v = {v[2:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] fill_word(input int idx);
        logic [15:0] a;
        a = 16'(idx);
        return {a ^ 16'h5a5a, ~a};
    endfunction

    function automatic bit is_err(input logic [31:0] addr);
        foreach (err_q[i]) begin
            if (err_q[i][9:2] == addr[9:2]) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic [31:0] beat_address(input logic [31:0] start, input logic [7:0] len,
                                                 input logic [1:0] burst, input int beat);
        logic [31:0] aligned;
        logic [31:0] window;
        logic [31:0] base;
        aligned = {start[31:3], 3'b000};
        window  = (32'(len) + 32'd1) * 32'd8;
        base    = aligned & ~(window - 32'd1);
        case (burst)
            2'd0:    return aligned;
            2'd2:    return base + ((aligned - base + 32'(beat) * 32'd8) % window);
            default: return aligned + 32'(beat) * 32'd8;
        endcase
    endfunction

    task automatic expect_read(input logic [45:0] c);
        logic [31:0] a;
        logic [1:0]  resp;
        for (int i = 0; i <= int'(c[9:2]); i++) begin
            a = beat_address(c[41:10], c[9:2], c[1:0], i);
            resp = (is_err(a) || is_err(a + 32'd4)) ? 2'b10 : 2'b00;
            exp_r.push_back({c[45:42], ref_mem[a[9:2] + 8'd1], ref_mem[a[9:2]], resp,
                             i == int'(c[9:2])});
        end
    endtask

    task automatic apply_writes();
        logic [31:0] wa;
        logic [72:0] b;
        bit          err;
        int          idx;
        idx = 0;
        foreach (aw_q[n]) begin
            err = 1'b0;
            for (int i = 0; i <= int'(aw_q[n][9:2]); i++) begin
                b = w_q[idx];
                idx++;
                for (int k = 0; k < 2; k++) begin
                    wa = beat_address(aw_q[n][41:10], aw_q[n][9:2], aw_q[n][1:0], i) + 32'(4 * k);
                    if (is_err(wa)) begin
                        err = 1'b1; // Errored words keep their old contents
                    end else begin
                        for (int j = 0; j < 4; j++) begin
                            if (b[1 + 4 * k + j]) begin
                                ref_mem[wa[9:2]][8 * j +: 8] = b[9 + 32 * k + 8 * j +: 8];
                            end
                        end
                    end
                end
            end
            exp_b.push_back({aw_q[n][45:42], err ? 2'b10 : 2'b00});
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI drivers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic send_reads();
        while (ar_q.size() > 0) begin
            {arid, araddr, arlen, arburst} = ar_q.pop_front();
            arvalid = 1'b1;
            while (!arready) @(negedge clk);
            @(negedge clk);
            arvalid = 1'b0;
        end
    endtask

    task automatic send_write_cmds();
        while (aw_q.size() > 0) begin
            {awid, awaddr, awlen, awburst} = aw_q.pop_front();
            awvalid = 1'b1;
            while (!awready) @(negedge clk);
            @(negedge clk);
            awvalid = 1'b0;
        end
    endtask

    task automatic send_write_data();
        while (w_q.size() > 0) begin
            {wdata, wstrb, wlast} = w_q.pop_front();
            wvalid = 1'b1;
            while (!wready) @(negedge clk);
            @(negedge clk);
            wvalid = 1'b0;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sinks and APB slave
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin : sinks_and_slave
        logic [3:0]  r;
        logic [70:0] er;
        logic [5:0]  eb;
        if (rst_n) begin
            take_bits(stall_mode ? 2 : 0, r);
            rready = stall_mode ? r[0] : 1'b1;
            bready = stall_mode ? r[1] : 1'b1;
            if (rvalid && rready) begin
                assert (exp_r.size() != 0) else begin
                    $display("R beat arrived with no read beat outstanding");
                    fail_now();
                end
                er = exp_r.pop_front();
                compare("rid", 64'(rid), 64'(er[70:67]));
                compare("rdata", rdata, er[66:3]);
                compare("rresp", 64'(rresp), 64'(er[2:1]));
                compare("rlast", 64'(rlast), 64'(er[0]));
            end
            if (bvalid && bready) begin
                assert (exp_b.size() != 0) else begin
                    $display("B response arrived with no write burst outstanding");
                    fail_now();
                end
                eb = exp_b.pop_front();
                compare("bid", 64'(bid), 64'(eb[5:2]));
                compare("bresp", 64'(bresp), 64'(eb[1:0]));
            end
            pready = 1'b0;
            presp  = 2'b00;
            if (psel && !penable) begin
                take_bits(stall_mode ? 2 : 0, r);
                wait_cnt = stall_mode ? int'(r[1:0]) : 0;
            end else if (psel && penable) begin
                if (wait_cnt > 0) begin
                    wait_cnt--;
                end else begin
                    pready = 1'b1;
                    prdata = apb_mem[paddr[9:2]];
                    if (is_err(paddr)) begin
                        presp = 2'b10;
                    end else if (pwrite) begin
                        for (int j = 0; j < 4; j++) begin
                            if (pstrb[j]) apb_mem[paddr[9:2]][8 * j +: 8] = pwdata[8 * j +: 8];
                        end
                    end
                end
            end
        end
    end

    initial begin : watchdog
        wait (budget_cycles > 0);
        repeat (budget_cycles) @(posedge clk);
        $display("Timeout: bursts did not complete within %0d cycles", budget_cycles);
        fail_now();
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : main
        int          fd;
        int          n;
        int          beats;
        int          w_left;
        string       line;
        byte         tag;
        logic [63:0] f0, f1, f2, f3;
        clk = 1'b0;
        rst_n = 1'b0;
        {arid, araddr, arlen, arburst, arvalid} = '0;
        {awid, awaddr, awlen, awburst, awvalid} = '0;
        {wdata, wstrb, wlast, wvalid} = '0;
        arsize = 3'd3;
        awsize = 3'd3;
        rready = 1'b1;
        bready = 1'b1;
        {pready, presp, prdata} = '0;
        lfsr = 32'h2e1a;
        stall_mode = 1'b0;
        wait_cnt = 0;
        errors = 0;
        beats = 0;
        w_left = 0;
        for (int i = 0; i < 256; i++) begin
            apb_mem[i] = fill_word(i);
            ref_mem[i] = fill_word(i);
        end

        fd = $fopen("verif/axi2apb_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the burst data file");
            fail_now();
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") lines.push_back(line);
        end
        $fclose(fd);
        foreach (lines[i]) begin
            n = $sscanf(lines[i].substr(1, lines[i].len() - 1), "%h %h %h %h", f0, f1, f2, f3);
            if (lines[i].getc(0) == "E") err_q.push_back(f0[31:0]);
            if (lines[i].getc(0) == "R" || lines[i].getc(0) == "W") beats += int'(f2[7:0]) + 1;
        end
        budget_cycles = beats * 40 + 200;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        foreach (lines[i]) begin
            tag = lines[i].getc(0);
            n = $sscanf(lines[i].substr(1, lines[i].len() - 1), "%h %h %h %h", f0, f1, f2, f3);
            case (tag)
                "S": stall_mode = f0[0];
                "R": begin
                    ar_q.push_back({f0[3:0], f1[31:0], f2[7:0], f3[1:0]});
                    expect_read({f0[3:0], f1[31:0], f2[7:0], f3[1:0]});
                end
                "W": begin
                    aw_q.push_back({f0[3:0], f1[31:0], f2[7:0], f3[1:0]});
                    w_left = int'(f2[7:0]) + 1;
                end
                "D": begin
                    w_left--;
                    w_q.push_back({f0, f1[7:0], w_left == 0});
                end
                "G": begin
                    apply_writes(); // Reads of a group see memory before its writes
                    fork
                        send_reads();
                        send_write_cmds();
                        send_write_data();
                    join
                    while (exp_r.size() != 0 || exp_b.size() != 0) @(negedge clk);
                end
                default: ;
            endcase
        end

        // Nothing more may arrive once every burst has completed
        repeat (20) @(negedge clk);
        assert (!rvalid && !bvalid) else begin
            $display("Extra response left after all bursts completed");
            errors++;
        end
        if (errors == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            fail_now();
        end
    end

endmodule

`default_nettype wire
